// ==== obj_attr_fetch.sv ====
`timescale 1ns/100ps

module obj_attr_fetch import obj_cfg_pkg::*, obj_bus_pkg::*; (
    input  logic      fclk,
    input  logic      rst,
    input  logic      line_start,
    input  line_y_t   line_y,
    input  logic      mem_ready,
    input  logic      mem_rvalid,
    input  axil_r_t   mem_r,
    input  logic      desc_ready,
    output axil_ar_t  mem_ar,
    output logic      mem_valid,
    output obj_desc_t desc,
    output logic      desc_valid,
    output logic      scan_done
);

    typedef enum logic [2:0] {
        AF_IDLE, AF_RD0, AF_EVAL, AF_RD1, AF_OFFER, AF_NEXT
    } af_state_t;

    af_state_t   state;
    obj_index_t  idx;
    logic        ar_sent;
    line_y_t     line_q;
    mem_data_t   word0;
    obj_desc_t   desc_q;
    logic [15:0] attr0;
    logic [15:0] attr1;
    sprite_dim_t obj_w;
    sprite_dim_t obj_h;
    line_y_t     diff;
    logic        wraps;
    logic        covered;
    logic        skip;

    always_comb begin
        attr0 = word0[15:0];
        attr1 = word0[31:16];
        case ({attr0[ATTR0_SHAPE_HI:ATTR0_SHAPE_LO], attr1[ATTR1_SIZE_HI:ATTR1_SIZE_LO]})
            4'b00_00: begin obj_w = 7'd8;  obj_h = 7'd8;  end // square
            4'b00_01: begin obj_w = 7'd16; obj_h = 7'd16; end
            4'b00_10: begin obj_w = 7'd32; obj_h = 7'd32; end
            4'b00_11: begin obj_w = 7'd64; obj_h = 7'd64; end
            4'b01_00: begin obj_w = 7'd16; obj_h = 7'd8;  end // wide
            4'b01_01: begin obj_w = 7'd32; obj_h = 7'd8;  end
            4'b01_10: begin obj_w = 7'd32; obj_h = 7'd16; end
            4'b01_11: begin obj_w = 7'd64; obj_h = 7'd32; end
            4'b10_00: begin obj_w = 7'd8;  obj_h = 7'd16; end // tall
            4'b10_01: begin obj_w = 7'd8;  obj_h = 7'd32; end
            4'b10_10: begin obj_w = 7'd16; obj_h = 7'd32; end
            4'b10_11: begin obj_w = 7'd32; obj_h = 7'd64; end
            default:  begin obj_w = 7'd8;  obj_h = 7'd8;  end
        endcase

        diff    = line_q - attr0[ATTR0_Y_HI:ATTR0_Y_LO];
        wraps   = ({1'b0, attr0[ATTR0_Y_HI:ATTR0_Y_LO]} + {2'b00, obj_h}) > 9'd255;
        covered = (diff < {1'b0, obj_h}) &&
                  (!wraps || line_q < attr0[ATTR0_Y_HI:ATTR0_Y_LO]);
        skip    = (attr0[ATTR0_ROT_HI:ATTR0_ROT_LO] != 2'b00) ||    // affine or off
                  (attr0[ATTR0_SHAPE_HI:ATTR0_SHAPE_LO] == 2'b11) ||
                  (attr0[ATTR0_MODE_HI:ATTR0_MODE_LO] == 2'b10) ||  // window
                  !covered;
    end

    assign mem_valid     = (state == AF_RD0 || state == AF_RD1) && !ar_sent;
    assign mem_ar.araddr = OAM_BASE + mem_addr_t'({idx, (state == AF_RD1), 2'b00});
    assign desc          = desc_q;
    assign desc_valid    = (state == AF_OFFER);

    always_ff @(posedge fclk) begin
        if (rst) begin
            state     <= AF_IDLE;
            idx       <= '0;
            ar_sent   <= 1'b0;
            scan_done <= 1'b1;
        end else begin
            case (state)
                AF_IDLE: begin
                    if (line_start) begin
                        idx       <= '0;
                        scan_done <= 1'b0;
                        state     <= AF_RD0;
                    end
                end
                AF_RD0, AF_RD1: begin
                    if (mem_ready)
                        ar_sent <= 1'b1;
                    if (mem_rvalid) begin
                        ar_sent <= 1'b0;
                        state   <= (state == AF_RD0) ? AF_EVAL : AF_OFFER;
                    end
                end
                AF_EVAL:  state <= skip ? AF_NEXT : AF_RD1;
                AF_OFFER: if (desc_ready) state <= AF_NEXT;
                AF_NEXT: begin
                    if (idx == obj_index_t'(OBJ_COUNT - 1)) begin
                        scan_done <= 1'b1;
                        state     <= AF_IDLE;
                    end else begin
                        idx   <= idx + 7'd1;
                        state <= AF_RD0;
                    end
                end
                default: state <= AF_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (state == AF_IDLE && line_start)
            line_q <= line_y;
        if (state == AF_RD0 && mem_rvalid)
            word0 <= mem_r.rdata;
        if (state == AF_EVAL) begin
            desc_q.x_pos   <= attr1[ATTR1_X_HI:ATTR1_X_LO];
            desc_q.width   <= obj_w;
            desc_q.height  <= obj_h;
            desc_q.hflip   <= attr1[ATTR1_HFLIP_HI:ATTR1_HFLIP_LO];
            desc_q.hicolor <= attr0[ATTR0_HICOLOR_HI:ATTR0_HICOLOR_LO];
            desc_q.alpha   <= (attr0[ATTR0_MODE_HI:ATTR0_MODE_LO] == 2'b01);
            if (attr1[ATTR1_VFLIP_HI:ATTR1_VFLIP_LO])
                desc_q.row <= obj_h - 7'd1 - sprite_dim_t'(diff);
            else
                desc_q.row <= sprite_dim_t'(diff);
        end
        if (state == AF_RD1 && mem_rvalid) begin // attr2 in low half
            desc_q.tile    <= mem_r.rdata[ATTR2_TILE_HI:ATTR2_TILE_LO];
            desc_q.prio    <= mem_r.rdata[ATTR2_PRIO_HI:ATTR2_PRIO_LO];
            desc_q.palette <= mem_r.rdata[ATTR2_PAL_HI:ATTR2_PAL_LO];
        end
    end

endmodule

// ==== obj_bus_pkg.sv ====
package obj_bus_pkg;

    import obj_cfg_pkg::*;

    typedef logic [15:0] mem_addr_t;
    typedef logic [31:0] mem_data_t;

    typedef struct packed {
        mem_addr_t araddr;
    } axil_ar_t;

    typedef struct packed {
        mem_data_t rdata;
    } axil_r_t;

    // one sprite line, vflip already applied to row
    typedef struct packed {
        logic [8:0]  x_pos;    // above 255 is negative
        sprite_dim_t row;
        sprite_dim_t width;
        sprite_dim_t height;
        logic        hflip;
        logic        hicolor;
        logic [9:0]  tile;
        logic [3:0]  palette;
        prio_t       prio;
        logic        alpha;
    } obj_desc_t;

    typedef struct packed {
        screen_x_t  x;
        color_idx_t color;
        prio_t      prio;
        logic       alpha;
    } obj_pixel_t;

endpackage

// ==== obj_cfg_pkg.sv ====
package obj_cfg_pkg;

    localparam int OBJ_COUNT  = 128;
    localparam int LINE_WIDTH = 240;

    localparam logic [15:0] OAM_BASE      = 16'h0000; // 8 bytes per entry
    localparam logic [15:0] VRAM_OBJ_BASE = 16'h8000; // 32 KB sprite tiles

    localparam int TILE_BYTES_4BPP  = 32;
    localparam int TILE_BYTES_8BPP  = 64;
    localparam int MAP_2D_ROW_BYTES = 1024;

    // attr0
    localparam int ATTR0_Y_LO       = 0;
    localparam int ATTR0_Y_HI       = 7;
    localparam int ATTR0_ROT_LO     = 8;  // affine bit
    localparam int ATTR0_ROT_HI     = 9;  // disable bit when not affine
    localparam int ATTR0_MODE_LO    = 10;
    localparam int ATTR0_MODE_HI    = 11;
    localparam int ATTR0_HICOLOR_LO = 13;
    localparam int ATTR0_HICOLOR_HI = 13;
    localparam int ATTR0_SHAPE_LO   = 14;
    localparam int ATTR0_SHAPE_HI   = 15;

    // attr1
    localparam int ATTR1_X_LO     = 0;
    localparam int ATTR1_X_HI     = 8;
    localparam int ATTR1_HFLIP_LO = 12;
    localparam int ATTR1_HFLIP_HI = 12;
    localparam int ATTR1_VFLIP_LO = 13;
    localparam int ATTR1_VFLIP_HI = 13;
    localparam int ATTR1_SIZE_LO  = 14;
    localparam int ATTR1_SIZE_HI  = 15;

    // attr2
    localparam int ATTR2_TILE_LO = 0;
    localparam int ATTR2_TILE_HI = 9;
    localparam int ATTR2_PRIO_LO = 10;
    localparam int ATTR2_PRIO_HI = 11;
    localparam int ATTR2_PAL_LO  = 12;
    localparam int ATTR2_PAL_HI  = 15;

    typedef logic [7:0]  screen_x_t;
    typedef logic [7:0]  line_y_t;
    typedef logic [6:0]  obj_index_t;
    typedef logic [1:0]  prio_t;
    typedef logic [7:0]  color_idx_t;
    typedef logic [6:0]  sprite_dim_t;  // 8 to 64
    typedef logic [14:0] vram_offset_t;

endpackage

// ==== obj_line_buffer.sv ====
`timescale 1ns/100ps

module obj_line_buffer import obj_cfg_pkg::*, obj_bus_pkg::*; (
    input  logic       fclk,
    input  logic       rst,
    input  logic       line_start,
    input  obj_pixel_t pix,
    input  logic       pix_valid,
    output logic       pixel_we,
    output obj_pixel_t pixel_out
);

    logic [LINE_WIDTH-1:0] valid_q;
    prio_t                 prio_mem [LINE_WIDTH];
    logic                  accept;

    // empty pixel or strictly better priority wins
    assign accept = pix_valid && !line_start &&
                    (!valid_q[pix.x] || pix.prio < prio_mem[pix.x]);

    always_ff @(posedge fclk) begin
        if (rst) begin
            valid_q  <= '0;
            pixel_we <= 1'b0;
        end else begin
            pixel_we <= accept;
            if (line_start)
                valid_q <= '0;
            else if (accept)
                valid_q[pix.x] <= 1'b1;
        end
    end

    always_ff @(posedge fclk) begin
        if (accept) begin
            prio_mem[pix.x] <= pix.prio;
            pixel_out       <= pix;
        end
    end

endmodule

// ==== obj_mem_arbiter.sv ====
`timescale 1ns/100ps

module obj_mem_arbiter import obj_bus_pkg::*; (
    input  logic      fclk,
    input  logic      rst,
    input  axil_ar_t  a_ar,
    input  axil_ar_t  b_ar,
    input  logic      a_valid,
    input  logic      b_valid,
    input  logic      arready,
    input  logic      rvalid,
    input  mem_data_t rdata,
    output logic      a_ready,
    output logic      b_ready,
    output logic      a_rvalid,
    output logic      b_rvalid,
    output axil_r_t   r,
    output logic      arvalid,
    output mem_addr_t araddr,
    output logic      rready
);

    typedef enum logic [1:0] {ARB_IDLE, ARB_ADDR, ARB_DATA} arb_state_t;

    arb_state_t state;
    logic       last_grant; // 1 = b, also owner of the open transaction
    logic       pick;

    always_comb begin
        if (a_valid && b_valid)
            pick = ~last_grant; // alternate on contention
        else
            pick = b_valid;
    end

    assign arvalid  = (state == ARB_ADDR);
    assign araddr   = last_grant ? b_ar.araddr : a_ar.araddr;
    assign rready   = (state == ARB_DATA);
    assign a_ready  = arvalid && arready && !last_grant;
    assign b_ready  = arvalid && arready && last_grant;
    assign a_rvalid = rready && rvalid && !last_grant;
    assign b_rvalid = rready && rvalid && last_grant;
    assign r.rdata  = rdata;

    always_ff @(posedge fclk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            last_grant <= 1'b1; // a wins the first contention
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (a_valid || b_valid) begin
                        last_grant <= pick;
                        state      <= ARB_ADDR;
                    end
                end
                ARB_ADDR: if (arready) state <= ARB_DATA;
                ARB_DATA: if (rvalid) state <= ARB_IDLE;
                default:  state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== obj_renderer.sv ====
`timescale 1ns/100ps

module obj_renderer import obj_cfg_pkg::*, obj_bus_pkg::*; (
    input  logic       fclk,
    input  logic       rst,
    input  logic       line_start,
    input  line_y_t    line_y,
    input  logic       one_dim_mapping,
    input  logic       arready,
    input  logic       rvalid,
    input  mem_data_t  rdata,
    output logic       busy,
    output logic       arvalid,
    output mem_addr_t  araddr,
    output logic       rready,
    output logic       pixel_we,
    output obj_pixel_t pixel_out
);

    axil_ar_t   attr_ar;
    axil_ar_t   tile_ar;
    axil_r_t    mem_r;
    logic       attr_valid;
    logic       tile_valid;
    logic       attr_ready;
    logic       tile_ready;
    logic       attr_rvalid;
    logic       tile_rvalid;
    obj_desc_t  desc;
    logic       desc_valid;
    logic       desc_ready;
    obj_pixel_t pix;
    logic       pix_valid;
    logic       scan_done;
    logic       tile_idle;
    logic       line_go;

    // scan finished and last sprite drawn
    assign busy    = !(scan_done && tile_idle);
    assign line_go = line_start && !busy; // new line only when idle

    obj_attr_fetch u_attr_fetch (
        .fclk       (fclk),
        .rst        (rst),
        .line_start (line_go),
        .line_y     (line_y),
        .mem_ready  (attr_ready),
        .mem_rvalid (attr_rvalid),
        .mem_r      (mem_r),
        .desc_ready (desc_ready),
        .mem_ar     (attr_ar),
        .mem_valid  (attr_valid),
        .desc       (desc),
        .desc_valid (desc_valid),
        .scan_done  (scan_done)
    );

    obj_tile_fetch u_tile_fetch (
        .fclk            (fclk),
        .rst             (rst),
        .one_dim_mapping (one_dim_mapping),
        .desc            (desc),
        .desc_valid      (desc_valid),
        .mem_ready       (tile_ready),
        .mem_rvalid      (tile_rvalid),
        .mem_r           (mem_r),
        .desc_ready      (desc_ready),
        .mem_ar          (tile_ar),
        .mem_valid       (tile_valid),
        .pix             (pix),
        .pix_valid       (pix_valid),
        .idle            (tile_idle)
    );

    obj_mem_arbiter u_arbiter (
        .fclk     (fclk),
        .rst      (rst),
        .a_ar     (attr_ar),
        .b_ar     (tile_ar),
        .a_valid  (attr_valid),
        .b_valid  (tile_valid),
        .arready  (arready),
        .rvalid   (rvalid),
        .rdata    (rdata),
        .a_ready  (attr_ready),
        .b_ready  (tile_ready),
        .a_rvalid (attr_rvalid),
        .b_rvalid (tile_rvalid),
        .r        (mem_r),
        .arvalid  (arvalid),
        .araddr   (araddr),
        .rready   (rready)
    );

    obj_line_buffer u_line_buffer (
        .fclk       (fclk),
        .rst        (rst),
        .line_start (line_go),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pixel_we   (pixel_we),
        .pixel_out  (pixel_out)
    );

endmodule

// ==== obj_tile_fetch.sv ====
`timescale 1ns/100ps

module obj_tile_fetch import obj_cfg_pkg::*, obj_bus_pkg::*; (
    input  logic       fclk,
    input  logic       rst,
    input  logic       one_dim_mapping,
    input  obj_desc_t  desc,
    input  logic       desc_valid,
    input  logic       mem_ready,
    input  logic       mem_rvalid,
    input  axil_r_t    mem_r,
    output logic       desc_ready,
    output axil_ar_t   mem_ar,
    output logic       mem_valid,
    output obj_pixel_t pix,
    output logic       pix_valid,
    output logic       idle
);

    typedef enum logic [1:0] {TF_IDLE, TF_SETUP, TF_COL, TF_READ} tf_state_t;

    tf_state_t    state;
    obj_desc_t    d_q;
    sprite_dim_t  col;
    logic         ar_sent;
    vram_offset_t row_base;   // tile base plus row terms
    logic [9:0]   tile_num;
    vram_offset_t tile_bytes;
    vram_offset_t stride;
    vram_offset_t row_term;
    vram_offset_t col_term;
    vram_offset_t offset;
    sprite_dim_t  mcol;
    logic [8:0]   sx;
    logic [7:0]   texel_byte;
    logic [3:0]   nibble;
    color_idx_t   color;
    logic         opaque;

    always_comb begin
        // 8bpp with 2d mapping addresses tiles in pairs
        tile_num   = (d_q.hicolor && !one_dim_mapping) ? {d_q.tile[9:1], 1'b0} : d_q.tile;
        tile_bytes = d_q.hicolor ? vram_offset_t'(TILE_BYTES_8BPP)
                                 : vram_offset_t'(TILE_BYTES_4BPP);
        stride     = one_dim_mapping ? vram_offset_t'(d_q.width[6:3]) * tile_bytes
                                     : vram_offset_t'(MAP_2D_ROW_BYTES);
        row_term   = vram_offset_t'(d_q.row[5:3]) * stride;
        if (d_q.hicolor)
            row_term = row_term + vram_offset_t'({d_q.row[2:0], 3'b000});
        else
            row_term = row_term + vram_offset_t'({d_q.row[2:0], 2'b00});

        mcol     = d_q.hflip ? (d_q.width - 7'd1 - col) : col;
        col_term = vram_offset_t'(mcol[5:3]) * tile_bytes;
        if (d_q.hicolor)
            col_term = col_term + vram_offset_t'(mcol[2:0]);
        else
            col_term = col_term + vram_offset_t'(mcol[2:1]); // two texels per byte
        offset = row_base + col_term;
        sx     = d_q.x_pos + {2'b00, col};  // wraps mod 512

        texel_byte = mem_r.rdata[{offset[1:0], 3'b000} +: 8];
        nibble     = mcol[0] ? texel_byte[7:4] : texel_byte[3:0];
        color      = d_q.hicolor ? texel_byte : {d_q.palette, nibble};
        opaque     = d_q.hicolor ? (texel_byte != 8'h00) : (nibble != 4'h0);
    end

    assign desc_ready    = (state == TF_IDLE);
    assign idle          = (state == TF_IDLE);
    assign mem_valid     = (state == TF_READ) && !ar_sent;
    assign mem_ar.araddr = VRAM_OBJ_BASE + {1'b0, offset};

    always_ff @(posedge fclk) begin
        if (rst) begin
            state     <= TF_IDLE;
            col       <= '0;
            ar_sent   <= 1'b0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= 1'b0;
            case (state)
                TF_IDLE: begin
                    if (desc_valid) begin
                        col   <= '0;
                        state <= TF_SETUP;
                    end
                end
                TF_SETUP: state <= TF_COL;
                TF_COL: begin
                    if (col == d_q.width)
                        state <= TF_IDLE;
                    else if (sx < LINE_WIDTH)
                        state <= TF_READ;
                    else
                        col <= col + 7'd1; // off screen, no read
                end
                TF_READ: begin
                    if (mem_ready)
                        ar_sent <= 1'b1;
                    if (mem_rvalid) begin
                        ar_sent   <= 1'b0;
                        pix_valid <= opaque;
                        col       <= col + 7'd1;
                        state     <= TF_COL;
                    end
                end
                default: state <= TF_IDLE;
            endcase
        end
    end

    always_ff @(posedge fclk) begin
        if (state == TF_IDLE && desc_valid)
            d_q <= desc;
        if (state == TF_SETUP)
            row_base <= vram_offset_t'({tile_num, 5'b00000}) + row_term;
        if (state == TF_READ && mem_rvalid) begin
            pix.x     <= sx[7:0];
            pix.color <= color;
            pix.prio  <= d_q.prio;
            pix.alpha <= d_q.alpha;
        end
    end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
    output logic fclk,
    output logic rst
);

    initial begin
        fclk = 1'b0;
        forever #5 fclk = ~fclk; // 100 MHz
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge fclk);
        @(negedge fclk);
        rst = 1'b0;
    end

endmodule

// ==== tb_obj_renderer.sv ====
`timescale 1ns/100ps

module tb_obj_renderer import obj_cfg_pkg::*, obj_bus_pkg::*; ();

    logic       fclk;
    logic       rst;
    logic       line_start;
    line_y_t    line_y;
    logic       one_dim_mapping;
    logic       arready;
    logic       rvalid;
    mem_data_t  rdata;
    logic       busy;
    logic       arvalid;
    mem_addr_t  araddr;
    logic       rready;
    logic       pixel_we;
    obj_pixel_t pixel_out;

    integer     seed = 32'hf9df_f6c6;
    logic [7:0] mem [0:65535];   // attribute table at 0 and sprite tiles from 0x8000
    logic       got_valid [LINE_WIDTH];
    obj_pixel_t got_pix [LINE_WIDTH];
    int         got_writes;
    logic       exp_valid [LINE_WIDTH];
    obj_pixel_t exp_pix [LINE_WIDTH];
    int         exp_writes;
    int         ar_wait;
    int         r_wait;
    logic       in_data;
    mem_addr_t  rd_addr;
    int         i;
    line_y_t    ly;

    tb_clock_gen u_clk (
        .fclk (fclk),
        .rst  (rst)
    );

    obj_renderer dut (
        .fclk            (fclk),
        .rst             (rst),
        .line_start      (line_start),
        .line_y          (line_y),
        .one_dim_mapping (one_dim_mapping),
        .arready         (arready),
        .rvalid          (rvalid),
        .rdata           (rdata),
        .busy            (busy),
        .arvalid         (arvalid),
        .araddr          (araddr),
        .rready          (rready),
        .pixel_we        (pixel_we),
        .pixel_out       (pixel_out)
    );

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            stop_on_error($sformatf("[ERROR] %s: got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_pixel(input screen_x_t x, input obj_pixel_t got, input obj_pixel_t exp);
        if (got.color !== exp.color)
            stop_on_error($sformatf("[ERROR] pixel_out.color x=0x%0h got 0x%0h expected 0x%0h",
                                    x, got.color, exp.color));
        else if (got.prio !== exp.prio)
            stop_on_error($sformatf("[ERROR] pixel_out.prio x=0x%0h got 0x%0h expected 0x%0h",
                                    x, got.prio, exp.prio));
        else if (got.alpha !== exp.alpha)
            stop_on_error($sformatf("[ERROR] pixel_out.alpha x=0x%0h got 0x%0h expected 0x%0h",
                                    x, got.alpha, exp.alpha));
    endtask

    function automatic int long_side(input logic [1:0] size);
        return (size == 2'd0) ? 16 : (size == 2'd3) ? 64 : 32;
    endfunction

    function automatic int short_side(input logic [1:0] size);
        return (size < 2'd2) ? 8 : (size == 2'd2) ? 16 : 32;
    endfunction

    // AXI4-Lite read slave with 0 to 3 wait cycles on each channel
    always @(negedge fclk) begin
        if (rst) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            in_data = 1'b0;
            ar_wait = -1;
        end else if (in_data) begin
            if (rvalid) begin
                rvalid  = 1'b0;
                in_data = 1'b0;
            end else if (r_wait == 0) begin
                if (rready !== 1'b1)
                    stop_on_error("read data ready but rready is low in the data phase");
                rvalid = 1'b1;
                rdata  = {mem[rd_addr + 3], mem[rd_addr + 2], mem[rd_addr + 1], mem[rd_addr]};
            end else begin
                r_wait--;
            end
        end else if (arready) begin
            arready = 1'b0; // address taken at the last rising edge
            in_data = 1'b1;
            r_wait  = $random(seed) & 3;
        end else if (arvalid === 1'b1) begin
            if (ar_wait < 0)
                ar_wait = $random(seed) & 3;
            if (ar_wait == 0) begin
                arready = 1'b1;
                rd_addr = {araddr[15:2], 2'b00};
                ar_wait = -1;
            end else begin
                ar_wait--;
            end
        end
    end

    // pixel write monitor
    always @(posedge fclk) begin
        if (rst === 1'b0 && pixel_we === 1'b1) begin
            if (pixel_out.x >= LINE_WIDTH)
                stop_on_error($sformatf("pixel written off screen at x=0x%0h", pixel_out.x));
            else if (pixel_out.color == 8'h00)
                stop_on_error("a transparent texel with colour index zero was written");
            else if (got_valid[pixel_out.x] && pixel_out.prio >= got_pix[pixel_out.x].prio)
                stop_on_error($sformatf("x=0x%0h rewritten with prio 0x%0h over prio 0x%0h",
                                        pixel_out.x, pixel_out.prio,
                                        got_pix[pixel_out.x].prio));
            else begin
                got_valid[pixel_out.x] = 1'b1;
                got_pix[pixel_out.x]   = pixel_out;
                got_writes++;
            end
        end
    end

    // reference line with entries taken in table order
    task automatic build_expected(input line_y_t y, input logic one_dim);
        int          n;
        int          w;
        int          h;
        int          ys;
        int          row;
        int          col;
        int          mcol;
        int          sx;
        int          tbytes;
        int          off;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        logic [7:0]  b;
        logic [3:0]  nib;
        logic        opaque;
        obj_pixel_t  p;
        exp_writes = 0;
        for (n = 0; n < LINE_WIDTH; n++)
            exp_valid[n] = 1'b0;
        for (n = 0; n < OBJ_COUNT; n++) begin
            a0 = {mem[8*n+1], mem[8*n]};
            a1 = {mem[8*n+3], mem[8*n+2]};
            a2 = {mem[8*n+5], mem[8*n+4]};
            if (a0[9:8] != 2'b00 || a0[15:14] == 2'b11 || a0[11:10] == 2'b10)
                continue;
            case (a0[15:14])
                2'b00: begin
                    w = 8 << a1[15:14];
                    h = w;
                end
                2'b01: begin
                    w = long_side(a1[15:14]);
                    h = short_side(a1[15:14]);
                end
                default: begin
                    w = short_side(a1[15:14]);
                    h = long_side(a1[15:14]);
                end
            endcase
            ys = a0[7:0];
            if (ys + h > 255)
                ys = ys - 256; // sprite starts above the screen
            row = int'(y) - ys;
            if (row < 0 || row >= h)
                continue;
            if (a1[13])
                row = h - 1 - row;
            tbytes = a0[13] ? 64 : 32;
            for (col = 0; col < w; col++) begin
                sx = (a1[8:0] + col) % 512;
                if (sx >= LINE_WIDTH)
                    continue;
                mcol = a1[12] ? w - 1 - col : col;
                off  = (a0[13] && !one_dim) ? (a2[9:1] * 64) : (a2[9:0] * 32);
                off  = off + (row / 8) * (one_dim ? (w / 8) * tbytes : 1024);
                off  = off + (row % 8) * (tbytes / 8) + (mcol / 8) * tbytes;
                off  = off + (a0[13] ? mcol % 8 : (mcol % 8) / 2);
                b    = mem[VRAM_OBJ_BASE + off % 32768];
                nib  = (mcol % 2) ? b[7:4] : b[3:0];
                opaque  = a0[13] ? (b != 8'h00) : (nib != 4'h0);
                p.x     = screen_x_t'(sx);
                p.color = a0[13] ? b : {a2[15:12], nib};
                p.prio  = a2[11:10];
                p.alpha = (a0[11:10] == 2'b01);
                if (opaque && (!exp_valid[sx] || p.prio < exp_pix[sx].prio)) begin
                    exp_valid[sx] = 1'b1;
                    exp_pix[sx]   = p;
                    exp_writes++;
                end
            end
        end
    endtask

    task automatic fill_table(input line_y_t base_y, input logic all_skipped);
        int          n;
        int          k;
        logic [15:0] a0;
        logic [15:0] a1;
        logic [15:0] a2;
        for (n = 0; n < OBJ_COUNT; n++) begin
            a0 = $random(seed);
            a1 = $random(seed);
            a2 = $random(seed);
            a0[7:0] = base_y - ($random(seed) & 31);
            if (all_skipped || ($random(seed) & 7) != 0) begin
                k = $random(seed) & 3;
                if (a0[15:14] == 2'b11)
                    a0[15:14] = 2'b01;
                case (k)
                    0: a0[9:8] = 2'b10; // disabled
                    1: a0[8] = 1'b1;    // affine
                    2: begin
                        a0[9:8]   = 2'b00;
                        a0[15:14] = 2'b11;
                    end
                    default: begin
                        a0[9:8]   = 2'b00;
                        a0[11:10] = 2'b10;
                    end
                endcase
            end else begin
                k = $unsigned($random(seed)) % 3;
                a0[9:8]   = 2'b00;
                a0[11:10] = {1'b0, a0[10]};  // normal or semi-transparent
                a0[15:14] = k[1:0];
                k = $random(seed) & 3;
                if (k == 1)
                    a1[8:0] = 9'd448 + ($random(seed) & 63); // partly left of 0
                else if (k == 2)
                    a1[8:0] = 9'd200 + ($random(seed) & 63); // across the right edge
            end
            mem[8*n]   = a0[7:0];
            mem[8*n+1] = a0[15:8];
            mem[8*n+2] = a1[7:0];
            mem[8*n+3] = a1[15:8];
            mem[8*n+4] = a2[7:0];
            mem[8*n+5] = a2[15:8];
        end
    endtask

    task automatic run_line(input line_y_t y, input logic one_dim);
        int t;
        int x;
        int seen;
        int got_cov;
        int exp_cov;
        @(negedge fclk);
        for (x = 0; x < LINE_WIDTH; x++)
            got_valid[x] = 1'b0;
        got_writes      = 0;
        one_dim_mapping = one_dim;
        line_y          = y;
        line_start      = 1'b1;
        @(negedge fclk);
        line_start = 1'b0;
        t = 0;
        while (!busy && t < 4) begin
            @(negedge fclk);
            t++;
        end
        if (!busy)
            stop_on_error("busy did not rise after line_start");
        t = 0;
        while (busy && t < 100000) begin
            line_start = (t % 256 == 255); // stray pulse, ignored while busy
            @(negedge fclk);
            t++;
        end
        line_start = 1'b0;
        if (busy)
            stop_on_error("timeout while waiting for busy to fall");
        if (arvalid !== 1'b0 || rready !== 1'b0)
            stop_on_error("a read is still outstanding after busy fell");
        @(negedge fclk);
        seen = got_writes;
        repeat (16) @(negedge fclk);
        check_count("pixel_we count after busy fell", got_writes, seen);

        build_expected(y, one_dim);
        check_count("pixel_we count", got_writes, exp_writes);
        got_cov = 0;
        exp_cov = 0;
        for (x = 0; x < LINE_WIDTH; x++) begin
            got_cov += got_valid[x];
            exp_cov += exp_valid[x];
        end
        check_count("covered pixels", got_cov, exp_cov);
        for (x = 0; x < LINE_WIDTH; x++) begin
            if (got_valid[x] !== exp_valid[x])
                stop_on_error($sformatf("[ERROR] pixel_we x=0x%0h got 0x%0h expected 0x%0h",
                                        x, got_valid[x], exp_valid[x]));
            else if (exp_valid[x])
                check_pixel(screen_x_t'(x), got_pix[x], exp_pix[x]);
        end
    endtask

    initial begin
        line_start      = 1'b0;
        line_y          = '0;
        one_dim_mapping = 1'b0;
        arready         = 1'b0;
        rvalid          = 1'b0;
        rdata           = '0;
        for (i = 0; i < 65536; i++) begin
            mem[i] = $random(seed);
            if (mem[i][7:5] == 3'b000)
                mem[i] = 8'h00; // more transparent texels
        end

        @(negedge fclk);
        i = 0;
        while (rst !== 1'b0 && i < 20) begin
            @(negedge fclk);
            i++;
        end
        if (rst !== 1'b0)
            stop_on_error("reset was never released");
        if (busy !== 1'b0 || arvalid !== 1'b0 || pixel_we !== 1'b0)
            stop_on_error("busy, arvalid or pixel_we not low after reset");

        // nothing drawable in the table
        fill_table(8'd40, 1'b1);
        run_line(8'd40, 1'b0);
        check_count("pixel_we count, all skipped", got_writes, 0);

        // pairs of lines over one table
        for (i = 0; i < 10; i++) begin
            ly = $unsigned($random(seed)) % 140;
            fill_table(ly + 8'd4, 1'b0);
            run_line(ly, $random(seed) & 1);
            run_line(ly + 1 + ($random(seed) & 15), $random(seed) & 1);
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== verilog.f ====
obj_cfg_pkg.sv
obj_bus_pkg.sv
obj_mem_arbiter.sv
obj_attr_fetch.sv
obj_tile_fetch.sv
obj_line_buffer.sv
obj_renderer.sv
tb_clock_gen.sv
tb_obj_renderer.sv
